//--- all.f
hdl/mipsPkg.sv
hdl/mainControl.sv
hdl/regFile.sv
hdl/alu.sv
hdl/pcUnit.sv
hdl/mipsCore.sv
test/clockGen.sv
test/mipsChecker.sv
test/tbMips.sv

//--- hdl/alu.sv
// integer alu for the core: add, sub, and, or, slt and a zero flag for beq
`default_nettype none

module alu
  import mipsPkg::*;
(
  input  wordT  a,
  input  wordT  b,
  input  aluOpT op,
  output wordT  result,
  output logic  zero
);

  // signed compare for slt
  logic lessThan;

  assign lessThan = ($signed(a) < $signed(b));

  // ======================================================================
  // operation select
  // ======================================================================
  always_comb begin
    case (op)
      aluAdd:  result = a + b;
      aluSub:  result = a - b;
      aluAnd:  result = a & b;
      aluOr:   result = a | b;
      // one in bit 0, upper bits clear
      aluSlt:  result = {31'b0, lessThan};
      // aluNone and anything else
      default: result = '0;
    endcase
  end

  // equal operands under sub
  // only meaningful together with branch
  assign zero = (result == '0);

endmodule

`default_nettype wire

//--- hdl/mainControl.sv
// instruction decoder; turns opcode and function field into one control struct for the core
`default_nettype none

module mainControl
  import mipsPkg::*;
(
  input  wordT ir,
  output ctrlT ctrl
);

  logic [5:0] opcode;
  logic [5:0] funct;
  aluOpT      rOp;

  assign opcode = ir[31:26];
  assign funct  = ir[5:0];

  // function field to alu op, R-type only
  always_comb begin
    case (funct)
      fnAdd:   rOp = aluAdd;
      fnSub:   rOp = aluSub;
      fnAnd:   rOp = aluAnd;
      fnOr:    rOp = aluOr;
      fnSlt:   rOp = aluSlt;
      default: rOp = aluNone;
    endcase
  end

  // ======================================================================
  // main decode
  // ======================================================================
  always_comb begin
    // start from all inactive, unknown codes keep this
    ctrl       = '0;
    ctrl.aluOp = aluNone;
    case (opcode)
      opRType: begin
        // unknown function leaves the struct idle
        if (rOp != aluNone) begin
          ctrl.regDst   = 1'b1;
          ctrl.regWrite = 1'b1;
          ctrl.aluOp    = rOp;
        end
      end
      opLw: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.memRead  = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.aluOp    = aluAdd;
      end
      opSw: begin
        // address only, nothing written back
        ctrl.aluSrc   = 1'b1;
        ctrl.memWrite = 1'b1;
        ctrl.aluOp    = aluAdd;
      end
      opBeq: begin
        // subtract so the zero flag means equal
        ctrl.branch = 1'b1;
        ctrl.aluOp  = aluSub;
      end
      opJ: begin
        ctrl.jump = 1'b1;
      end
      opJal: begin
        ctrl.jump     = 1'b1;
        ctrl.link     = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      default: ;
    endcase
  end

  // load and store never share a cycle, nor do branch and jump
  always_comb begin
    assert (!(ctrl.memRead && ctrl.memWrite))
      else $error("decoder drives memRead and memWrite together, ir %h", ir);
    assert (!(ctrl.jump && ctrl.branch))
      else $error("decoder drives jump and branch together, ir %h", ir);
  end

endmodule

`default_nettype wire

//--- hdl/mipsCore.sv
// top of the single-cycle MIPS core; wires decoder, register file, alu and pc to the memories
`default_nettype none

module mipsCore
  import mipsPkg::*;
#(
  parameter wordT resetVector = '0,
  parameter int   dmemAddrW   = 7
) (
  input  logic                 clk,
  input  logic                 rst,
  // instruction port
  output wordT                 irAddr,
  input  wordT                 ir,
  // write-back value, for observation
  output wordT                 rfWriteData,
  // data memory, strobes active low
  input  wordT                 readDataMem,
  output logic                 cen,
  output logic                 wen,
  output logic                 oen,
  output logic [dmemAddrW-1:0] memAddr,
  output wordT                 writeDataMem
);

  ctrlT    ctrl;
  regAddrT rs;
  regAddrT rt;
  regAddrT rd;
  regAddrT writeReg;
  wordT    signExtImm;
  wordT    readData1;
  wordT    readData2;
  wordT    aluB;
  wordT    aluResult;
  wordT    pc;
  wordT    pcPlus8;
  logic    aluZero;
  logic    regWriteEn;

  // ======================================================================
  // instruction fields
  // ======================================================================
  assign rs         = ir[25:21];
  assign rt         = ir[20:16];
  assign rd         = ir[15:11];
  assign signExtImm = {{16{ir[15]}}, ir[15:0]};

  mainControl uCtrl (
    .ir   (ir),
    .ctrl (ctrl)
  );

  // jal goes to r31, R-type to rd, loads to rt
  assign writeReg   = ctrl.link ? 5'd31 : (ctrl.regDst ? rd : rt);
  // no register writes while held in reset
  assign regWriteEn = ctrl.regWrite && rst;

  regFile uRegs (
    .clk       (clk),
    .rst       (rst),
    .writeEn   (regWriteEn),
    .readAddr1 (rs),
    .readAddr2 (rt),
    .writeAddr (writeReg),
    .writeData (rfWriteData),
    .readData1 (readData1),
    .readData2 (readData2)
  );

  // immediate for lw/sw offsets
  assign aluB = ctrl.aluSrc ? signExtImm : readData2;

  alu uAlu (
    .a      (readData1),
    .b      (aluB),
    .op     (ctrl.aluOp),
    .result (aluResult),
    .zero   (aluZero)
  );

  pcUnit #(
    .resetVector (resetVector)
  ) uPc (
    .clk          (clk),
    .rst          (rst),
    .imm26        (ir[25:0]),
    .branchOffset (signExtImm),
    .branch       (ctrl.branch),
    .jump         (ctrl.jump),
    .zero         (aluZero),
    .pc           (pc),
    .pcPlus8      (pcPlus8)
  );

  assign irAddr = pc;

  // write-back: link address, load data, else alu
  assign rfWriteData = ctrl.link ? pcPlus8 : (ctrl.memToReg ? readDataMem : aluResult);

  // ======================================================================
  // data memory side
  // ======================================================================
  // word address, byte offset bits dropped
  assign memAddr      = aluResult[dmemAddrW+1:2];
  assign writeDataMem = readData2;

  // strobes stay high through reset
  assign cen = !(rst && (ctrl.memRead || ctrl.memWrite));
  assign wen = !(rst && ctrl.memWrite);
  assign oen = !(rst && ctrl.memRead);

endmodule

`default_nettype wire

//--- hdl/mipsPkg.sv
// shared types and encodings for the single-cycle MIPS core; imported by every RTL module
`default_nettype none

package mipsPkg;

  // ======================================================================
  // basic datapath types
  // ======================================================================

  // one machine word, used for every datapath value
  typedef logic [31:0] wordT;

  // register index as found in rs, rt and rd
  typedef logic [4:0] regAddrT;

  // ======================================================================
  // instruction encodings
  // ======================================================================

  // primary opcodes, ir[31:26]
  localparam logic [5:0] opRType = 6'h00;
  localparam logic [5:0] opJ     = 6'h02;
  localparam logic [5:0] opJal   = 6'h03;
  localparam logic [5:0] opBeq   = 6'h04;
  localparam logic [5:0] opLw    = 6'h23;
  localparam logic [5:0] opSw    = 6'h2b;

  // R-type function field, ir[5:0]
  localparam logic [5:0] fnAdd = 6'h20;
  localparam logic [5:0] fnSub = 6'h22;
  localparam logic [5:0] fnAnd = 6'h24;
  localparam logic [5:0] fnOr  = 6'h25;
  localparam logic [5:0] fnSlt = 6'h2a;

  // alu operation select; aluNone makes the alu output zero
  typedef enum logic [2:0] {
    aluNone = 3'd0,
    aluAdd  = 3'd1,
    aluSub  = 3'd2,
    aluAnd  = 3'd3,
    aluOr   = 3'd4,
    aluSlt  = 3'd5
  } aluOpT;

  // ======================================================================
  // decoder output, one struct per instruction
  // ======================================================================
  typedef struct packed {
    logic  regDst;    // write register from rd, else rt
    logic  aluSrc;    // second operand is the immediate
    logic  memToReg;  // write back the load data
    logic  memRead;
    logic  memWrite;
    logic  regWrite;
    logic  branch;    // beq
    logic  jump;      // j and jal
    logic  link;      // jal, writes r31
    aluOpT aluOp;
  } ctrlT;

endpackage

`default_nettype wire

//--- hdl/pcUnit.sv
// program counter and next-address logic: jump, taken branch, or the next word
`default_nettype none

module pcUnit
  import mipsPkg::*;
#(
  parameter wordT resetVector = '0
) (
  input  logic        clk,
  input  logic        rst,
  input  logic [25:0] imm26,
  input  wordT        branchOffset,
  input  logic        branch,
  input  logic        jump,
  input  logic        zero,
  output wordT        pc,
  output wordT        pcPlus8
);

  wordT pcPlus4;
  wordT jumpTarget;
  wordT branchTarget;
  wordT nextPc;

  assign pcPlus4 = pc + 32'd4;
  // link value for jal
  assign pcPlus8 = pc + 32'd8;

  // region bits of pc+4, then the word index
  assign jumpTarget = {pcPlus4[31:28], imm26, 2'b00};

  // offset counts words relative to the delay slot address
  assign branchTarget = pcPlus4 + {branchOffset[29:0], 2'b00};

  // ======================================================================
  // next address, jump first
  // ======================================================================
  always_comb begin
    if (jump) begin
      nextPc = jumpTarget;
    end else if (branch && zero) begin
      nextPc = branchTarget;
    end else begin
      nextPc = pcPlus4;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= resetVector;
    end else begin
      pc <= nextPc;
    end
  end

  // every fetch stays on a word boundary
  assert property (@(posedge clk) pc[1:0] == 2'b00)
    else $error("pc not word aligned: %h", pc);

endmodule

`default_nettype wire

//--- hdl/regFile.sv
// 32-entry register file with two combinational read ports and one edge-triggered write
`default_nettype none

module regFile
  import mipsPkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    writeEn,
  input  regAddrT readAddr1,
  input  regAddrT readAddr2,
  input  regAddrT writeAddr,
  input  wordT    writeData,
  output wordT    readData1,
  output wordT    readData2
);

  // r0 has no storage
  wordT regs [1:31];

  // all registers start at zero after reset
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn && (writeAddr != '0)) begin
      regs[writeAddr] <= writeData;
    end
  end

  // reads of r0 give zero
  assign readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
  assign readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];

  // core must hold regWrite off while in reset
  assert property (@(posedge clk) !rst |-> !writeEn)
    else $error("register write enabled during reset, addr %0d", writeAddr);

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -sv -f all.f --top-module tbMips -Mdir obj_dir

out=$(./obj_dir/VtbMips)
echo "$out"

if echo "$out" | grep -q "all tests passed"; then
  exit 0
fi
exit 1

//--- test/clockGen.sv
// free-running testbench clock, 8 ns period, instantiated once by the testbench top
`default_nettype none

module clockGen (
  output logic clk
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
  end

  // half period of 4 ns
  always #4 clk = ~clk;

endmodule

`default_nettype wire

//--- test/mipsChecker.sv
// instruction-level reference model of the core; compares the DUT ports once per clock
`default_nettype none

module mipsChecker
  import mipsPkg::*;
#(
  parameter wordT resetVector = '0,
  parameter int   dmemAddrW   = 7,
  parameter int   progLen     = 64
) (
  input  logic                 clk,
  input  logic                 rst,
  input  wordT                 prog [progLen],
  input  wordT                 irAddr,
  input  wordT                 rfWriteData,
  input  logic                 cen,
  input  logic                 wen,
  input  logic                 oen,
  input  logic [dmemAddrW-1:0] memAddr,
  input  wordT                 writeDataMem,
  output int                   errorCount,
  output int                   checkCount
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int progW = $clog2(progLen);

  // architectural state of the model
  wordT regs [32];
  wordT mem [2**dmemAddrW];
  wordT pc;
  int   errors = 0;
  int   checks = 0;

  assign errorCount = errors;
  assign checkCount = checks;

  task automatic checkWord(input string name, input wordT expected, input wordT actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAILED %s expected %h actual %h at %0t", name, expected, actual, $time);
    end
  endtask

  // active-low strobes as seen on the data port
  task automatic checkStrobes(input logic expCen, input logic expWen, input logic expOen);
    checkWord("cen", 32'(expCen), 32'(cen));
    checkWord("wen", 32'(expWen), 32'(wen));
    checkWord("oen", 32'(expOen), 32'(oen));
  endtask

  // ======================================================================
  // one instruction per call
  // ======================================================================
  task automatic stepModel();
    wordT                 inst;
    logic [5:0]           op;
    regAddrT              rs;
    regAddrT              rt;
    regAddrT              rd;
    wordT                 a;
    wordT                 b;
    wordT                 simm;
    wordT                 pcPlus4;
    wordT                 nextPc;
    wordT                 res;
    wordT                 addr;
    logic [dmemAddrW-1:0] idx;
    inst    = prog[pc[progW+1:2]];
    op      = inst[31:26];
    rs      = inst[25:21];
    rt      = inst[20:16];
    rd      = inst[15:11];
    a       = regs[rs];
    b       = regs[rt];
    simm    = {{16{inst[15]}}, inst[15:0]};
    pcPlus4 = pc + 32'd4;
    nextPc  = pcPlus4;
    // byte address to word index
    addr    = a + simm;
    idx     = addr[dmemAddrW+1:2];
    checkWord("irAddr", pc, irAddr);
    case (op)
      opRType: begin
        case (inst[5:0])
          fnAdd:   res = a + b;
          fnSub:   res = a - b;
          fnAnd:   res = a & b;
          fnOr:    res = a | b;
          fnSlt:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          default: res = '0;
        endcase
        checkStrobes(1'b1, 1'b1, 1'b1);
        checkWord("rfWriteData", res, rfWriteData);
        if (rd != 5'd0) begin
          regs[rd] = res;
        end
      end
      opLw: begin
        checkStrobes(1'b0, 1'b1, 1'b0);
        checkWord("memAddr", 32'(idx), 32'(memAddr));
        // unwritten words read as zero
        checkWord("rfWriteData", mem[idx], rfWriteData);
        if (rt != 5'd0) begin
          regs[rt] = mem[idx];
        end
      end
      opSw: begin
        checkStrobes(1'b0, 1'b0, 1'b1);
        checkWord("memAddr", 32'(idx), 32'(memAddr));
        checkWord("writeDataMem", b, writeDataMem);
        mem[idx] = b;
      end
      opBeq: begin
        checkStrobes(1'b1, 1'b1, 1'b1);
        if (a == b) begin
          nextPc = pcPlus4 + {simm[29:0], 2'b00};
        end
      end
      opJ: begin
        checkStrobes(1'b1, 1'b1, 1'b1);
        nextPc = {pcPlus4[31:28], inst[25:0], 2'b00};
      end
      opJal: begin
        checkStrobes(1'b1, 1'b1, 1'b1);
        // link value is two words past the jal
        checkWord("rfWriteData", pc + 32'd8, rfWriteData);
        regs[31] = pc + 32'd8;
        nextPc   = {pcPlus4[31:28], inst[25:0], 2'b00};
      end
      default: begin
        errors++;
        $display("unknown opcode %h in the program at address %h", op, pc);
      end
    endcase
    pc = nextPc;
  endtask

  // outputs settle after the rising edge, so sample on the falling one
  always @(negedge clk) begin
    if (!rst) begin
      // pc parked at the reset vector, data port idle
      checkWord("irAddr", resetVector, irAddr);
      checkStrobes(1'b1, 1'b1, 1'b1);
      pc = resetVector;
      for (int r = 0; r < 32; r++) begin
        regs[r] = '0;
      end
      for (int m = 0; m < 2**dmemAddrW; m++) begin
        mem[m] = '0;
      end
    end else begin
      stepModel();
    end
  end

endmodule

`default_nettype wire

//--- test/tbMips.sv
// testbench top: random program, memory models, DUT, checker and watchdog for the MIPS core
`default_nettype none

module tbMips
  import mipsPkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam wordT        resetVector   = 32'h0;
  localparam int          dmemAddrW     = 7;
  localparam int          progLen       = 64;
  localparam int          resetCycles   = 8;
  localparam int          clkPeriod     = 8;
  localparam int          timeoutCycles = resetCycles + progLen * 4 + 20;
  localparam logic [31:0] seed          = 32'hb40d_47ba;
  // fetch address of the closing self loop
  localparam wordT        lastAddr      = 32'((progLen - 1) * 4);

  logic                 clk;
  logic                 rst;
  wordT                 irAddr;
  wordT                 ir;
  wordT                 rfWriteData;
  wordT                 readDataMem;
  logic                 cen;
  logic                 wen;
  logic                 oen;
  logic [dmemAddrW-1:0] memAddr;
  wordT                 writeDataMem;
  wordT                 imem [progLen];
  wordT                 dmem [2**dmemAddrW];
  logic [31:0]          lfsrState;
  int                   errorCount;
  int                   checkCount;

  // ======================================================================
  // random source
  // ======================================================================
  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit
  task automatic takeBits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsrState = lfsrNext(lfsrState);
      v = {v[30:0], lfsrState[0]};
    end
  endtask

  // r1 to r31, zero folds onto r1
  task automatic pickReg(output logic [4:0] r);
    logic [31:0] v;
    takeBits(5, v);
    r = (v[4:0] == 5'd0) ? 5'd1 : v[4:0];
  endtask

  // forward only, at most four words ahead, clipped to the last word
  task automatic pickTarget(input int i, output int t);
    logic [31:0] v;
    takeBits(2, v);
    t = i + 1 + int'(v);
    if (t > progLen - 1) begin
      t = progLen - 1;
    end
  endtask

  task automatic writeProgram();
    logic [31:0] kind;
    logic [31:0] v;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [5:0]  fn;
    int          t;
    wordT        w;
    for (int i = 0; i < progLen - 1; i++) begin
      takeBits(4, kind);
      pickReg(rs);
      pickReg(rt);
      pickReg(rd);
      case (kind[3:0])
        // base r0, word offset 0..508
        4'd6, 4'd7: begin
          takeBits(7, v);
          w = {opLw, 5'd0, rt, 16'(v << 2)};
        end
        4'd8, 4'd9: begin
          takeBits(7, v);
          w = {opSw, 5'd0, rt, 16'(v << 2)};
        end
        4'd10, 4'd11: begin
          pickTarget(i, t);
          w = {opBeq, rs, rt, 16'(t - i - 1)};
        end
        4'd12: begin
          pickTarget(i, t);
          w = {opJ, 26'(t)};
        end
        4'd13: begin
          pickTarget(i, t);
          w = {opJal, 26'(t)};
        end
        default: begin
          takeBits(3, v);
          case (v % 5)
            0:       fn = fnAdd;
            1:       fn = fnSub;
            2:       fn = fnAnd;
            3:       fn = fnOr;
            default: fn = fnSlt;
          endcase
          w = {opRType, rs, rt, rd, 5'd0, fn};
        end
      endcase
      imem[i] <= w;
    end
    // self loop ends the program
    imem[progLen-1] <= {opJ, 26'(progLen - 1)};
  endtask

  // ======================================================================
  // memory models, both answer in the same cycle
  // ======================================================================
  assign ir          = imem[irAddr[$clog2(progLen)+1:2]];
  assign readDataMem = (!cen && !oen) ? dmem[memAddr] : '0;

  always @(posedge clk) begin
    if (!cen && !wen) begin
      dmem[memAddr] <= writeDataMem;
    end
  end

  clockGen uClk (
    .clk (clk)
  );

  mipsCore #(
    .resetVector (resetVector),
    .dmemAddrW   (dmemAddrW)
  ) DUT (
    .clk          (clk),
    .rst          (rst),
    .irAddr       (irAddr),
    .ir           (ir),
    .rfWriteData  (rfWriteData),
    .readDataMem  (readDataMem),
    .cen          (cen),
    .wen          (wen),
    .oen          (oen),
    .memAddr      (memAddr),
    .writeDataMem (writeDataMem)
  );

  mipsChecker #(
    .resetVector (resetVector),
    .dmemAddrW   (dmemAddrW),
    .progLen     (progLen)
  ) uCheck (
    .clk          (clk),
    .rst          (rst),
    .prog         (imem),
    .irAddr       (irAddr),
    .rfWriteData  (rfWriteData),
    .cen          (cen),
    .wen          (wen),
    .oen          (oen),
    .memAddr      (memAddr),
    .writeDataMem (writeDataMem),
    .errorCount   (errorCount),
    .checkCount   (checkCount)
  );

  // ======================================================================
  // reset, program load and run
  // ======================================================================
  initial begin
    rst       = 1'b0;
    lfsrState = seed;
    for (int i = 0; i < progLen; i++) begin
      imem[i] = '0;
    end
    for (int i = 0; i < 2**dmemAddrW; i++) begin
      dmem[i] = '0;
    end
    @(posedge clk);
    writeProgram();
    repeat (resetCycles - 1) @(posedge clk);
    rst <= 1'b1;
    // run until the fetch reaches the closing self loop
    while (irAddr !== lastAddr) begin
      @(negedge clk);
    end
    // a few turns of the loop for the checker
    repeat (4) @(posedge clk);
    $display("%0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0 && checkCount > 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(timeoutCycles * clkPeriod);
    $display("run timed out after %0d cycles, %0d errors so far", timeoutCycles, errorCount);
    $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire
